//--- core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int RegDataWidth = 32;
  localparam int RegAddrWidth = 5;
  localparam int LsuOpWidth   = 4;

  typedef logic [RegDataWidth-1:0] reg_data_t;
  typedef logic [RegAddrWidth-1:0] reg_addr_t;

  // [3] load, [2] unsigned load, [1:0] access size
  typedef logic [LsuOpWidth-1:0] lsu_op_t;

  localparam int LsuLoadBit     = 3;
  localparam int LsuUnsignedBit = 2;

  // size field codes, anything else is treated as a word
  localparam logic [1:0] LsuSizeByte = 2'd0;
  localparam logic [1:0] LsuSizeHalf = 2'd1;

  // one instruction entering the memory stage
  typedef struct packed {
    logic      lsu;
    lsu_op_t   lsu_op;
    reg_data_t alu_res;
    reg_data_t store_data;
    logic      rd_en;
    reg_addr_t rd_addr;
  } mem_req_t;

  // writeback result
  typedef struct packed {
    logic      rd_en;
    reg_addr_t rd_addr;
    reg_data_t rd_data;
  } wb_t;

endpackage : core_pkg

`default_nettype wire

//--- axi_mem_if.sv
`timescale 1ns/1ns
`default_nettype none

// single-beat AXI4 master bus, only the signals that carry information
interface axi_mem_if #(
  parameter int AxiDataWidth = 64
) ();

  // write address
  logic [31:0]               awaddr;
  logic [2:0]                awsize;
  logic                      awvalid;
  logic                      awready;

  // write data
  logic [AxiDataWidth-1:0]   wdata;
  logic [AxiDataWidth/8-1:0] wstrb;
  logic                      wvalid;
  logic                      wready;

  // write response, code ignored
  logic                      bvalid;
  logic                      bready;

  // read address
  logic [31:0]               araddr;
  logic [2:0]                arsize;
  logic                      arvalid;
  logic                      arready;

  // read data
  logic [AxiDataWidth-1:0]   rdata;
  logic                      rvalid;
  logic                      rready;

  modport master (
    output awaddr, awsize, awvalid, input awready,
    output wdata, wstrb, wvalid, input wready,
    input bvalid, output bready,
    output araddr, arsize, arvalid, input arready,
    input rdata, rvalid, output rready
  );

  modport slave (
    input awaddr, awsize, awvalid, output awready,
    input wdata, wstrb, wvalid, output wready,
    output bvalid, input bready,
    input araddr, arsize, arvalid, output arready,
    output rdata, rvalid, input rready
  );

endinterface : axi_mem_if

`default_nettype wire

//--- pipe_buffer.sv
`timescale 1ns/1ns
`default_nettype none

// two-entry buffer, ready and valid both come straight from flops
module pipe_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  payload_t   mem_q [2];
  logic [1:0] count_q;
  logic [1:0] count_d;
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic       push;
  logic       pop;

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // push and pop together leave the fill level alone
  assign count_d = count_q + {1'b0, push} - {1'b0, pop};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q  <= 2'd0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      in_ready <= 1'b1;
    end else begin
      count_q  <= count_d;
      // stays up until both entries are taken
      in_ready <= (count_d != 2'd2);
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data;
    end
  end

  assign out_valid = (count_q != 2'd0);
  assign out_data  = mem_q[rd_ptr_q];

endmodule : pipe_buffer

`default_nettype wire

//--- lsu_align.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_align #(
  parameter int AxiDataWidth = 64
) (
  input  core_pkg::lsu_op_t         lsu_op,
  input  core_pkg::reg_data_t       addr,
  input  core_pkg::reg_data_t       store_data,
  input  logic [AxiDataWidth-1:0]   rdata,
  output logic [AxiDataWidth-1:0]   wdata,
  output logic [AxiDataWidth/8-1:0] wstrb,
  output logic [2:0]                size,
  output core_pkg::reg_data_t       load_data
);

  localparam int ByteLanes   = AxiDataWidth / 8;
  localparam int OffsetWidth = $clog2(ByteLanes);

  logic [OffsetWidth-1:0]  offset;
  logic [ByteLanes-1:0]    size_mask;
  logic [AxiDataWidth-1:0] rdata_shifted;
  logic                    is_unsigned;

  assign offset      = addr[OffsetWidth-1:0];
  assign is_unsigned = lsu_op[core_pkg::LsuUnsignedBit];
  assign size        = {1'b0, lsu_op[1:0]};

  // store data copied into every lane, strobes pick the addressed bytes
  always_comb begin
    if (lsu_op[1:0] == core_pkg::LsuSizeByte) begin
      wdata     = {ByteLanes{store_data[7:0]}};
      size_mask = ByteLanes'(4'b0001);
    end else if (lsu_op[1:0] == core_pkg::LsuSizeHalf) begin
      wdata     = {(ByteLanes / 2){store_data[15:0]}};
      size_mask = ByteLanes'(4'b0011);
    end else begin
      wdata     = {(ByteLanes / 4){store_data}};
      size_mask = ByteLanes'(4'b1111);
    end
  end

  assign wstrb = size_mask << offset;

  // addressed byte moved down to lane 0
  assign rdata_shifted = rdata >> {offset, 3'b000};

  always_comb begin
    if (lsu_op[1:0] == core_pkg::LsuSizeByte) begin
      load_data = is_unsigned ? {24'h0, rdata_shifted[7:0]}
                              : {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
    end else if (lsu_op[1:0] == core_pkg::LsuSizeHalf) begin
      load_data = is_unsigned ? {16'h0, rdata_shifted[15:0]}
                              : {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
    end else begin
      load_data = rdata_shifted[31:0];
    end
  end

endmodule : lsu_align

`default_nettype wire

//--- mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage #(
  parameter int AxiDataWidth = 64
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid,
  output logic               req_ready,
  input  core_pkg::mem_req_t req,
  output logic               res_valid,
  input  logic               res_ready,
  output core_pkg::wb_t      res,
  axi_mem_if.master          axi
);

  typedef enum logic [2:0] {
    StIdle,
    StWrite,
    StWriteResp,
    StRead,
    StReadData,
    StHold
  } state_e;

  state_e              state_q;
  state_e              state_d;
  core_pkg::mem_req_t  req_q;
  core_pkg::wb_t       res_q;
  core_pkg::reg_data_t load_data;
  logic                aw_done_q;
  logic                w_done_q;
  logic                aw_fire;
  logic                w_fire;
  logic                req_fire;
  logic                is_load;
  logic                mem_done;

  lsu_align #(
    .AxiDataWidth(AxiDataWidth)
  ) i_align (
    .lsu_op    (req_q.lsu_op),
    .addr      (req_q.alu_res),
    .store_data(req_q.store_data),
    .rdata     (axi.rdata),
    .wdata     (axi.wdata),
    .wstrb     (axi.wstrb),
    .size      (axi.awsize),
    .load_data (load_data)
  );

  assign is_load  = req_q.lsu_op[core_pkg::LsuLoadBit];
  assign aw_fire  = axi.awvalid && axi.awready;
  assign w_fire   = axi.wvalid && axi.wready;
  assign mem_done = (state_q == StWriteResp && axi.bvalid) ||
                    (state_q == StReadData && axi.rvalid);

  assign axi.awaddr  = req_q.alu_res;
  assign axi.araddr  = req_q.alu_res;
  assign axi.arsize  = axi.awsize;
  assign axi.awvalid = (state_q == StWrite) && !aw_done_q;
  assign axi.wvalid  = (state_q == StWrite) && !w_done_q;
  assign axi.bready  = (state_q == StWriteResp);
  assign axi.arvalid = (state_q == StRead);
  assign axi.rready  = (state_q == StReadData);

  // non-memory requests go straight through while idle
  assign req_ready = (state_q == StIdle) && (req.lsu || res_ready);
  assign req_fire  = req_valid && req_ready;
  assign res_valid = (state_q == StHold) || (state_q == StIdle && req_valid && !req.lsu);
  assign res       = (state_q == StHold) ? res_q
                   : '{rd_en: req.rd_en, rd_addr: req.rd_addr, rd_data: req.alu_res};

  always_comb begin
    state_d = state_q;
    case (state_q)
      StIdle: begin
        if (req_fire && req.lsu) begin
          state_d = req.lsu_op[core_pkg::LsuLoadBit] ? StRead : StWrite;
        end
      end
      // AW and W may finish in either order
      StWrite: begin
        if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
          state_d = StWriteResp;
        end
      end
      StWriteResp: if (axi.bvalid) state_d = StHold;
      StRead:      if (axi.arready) state_d = StReadData;
      StReadData:  if (axi.rvalid) state_d = StHold;
      StHold:      if (res_ready) state_d = StIdle;
      default:     state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= StIdle;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_d != StWrite) begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end else begin
        if (aw_fire) aw_done_q <= 1'b1;
        if (w_fire) w_done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire && req.lsu) begin
      req_q <= req;
    end
    // result built when the bus transaction ends
    if (mem_done) begin
      res_q <= '{rd_en:   req_q.rd_en,
                 rd_addr: req_q.rd_addr,
                 rd_data: is_load ? load_data : req_q.alu_res};
    end
  end

endmodule : mem_stage

`default_nettype wire

//--- mem_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsys #(
  parameter int AxiDataWidth = 64
) (
  input  logic                      clk,
  input  logic                      rst_n,

  // issue stream
  input  logic                      issue_valid,
  output logic                      issue_ready,
  input  logic                      issue_lsu,
  input  core_pkg::lsu_op_t         issue_lsu_op,
  input  core_pkg::reg_data_t       issue_alu_res,
  input  core_pkg::reg_data_t       issue_store_data,
  input  logic                      issue_rd_en,
  input  core_pkg::reg_addr_t       issue_rd_addr,

  // writeback stream
  output logic                      wb_valid,
  input  logic                      wb_ready,
  output logic                      wb_rd_en,
  output core_pkg::reg_addr_t       wb_rd_addr,
  output core_pkg::reg_data_t       wb_rd_data,

  // AXI master
  output logic [31:0]               axi_awaddr,
  output logic [2:0]                axi_awsize,
  output logic                      axi_awvalid,
  input  logic                      axi_awready,
  output logic [AxiDataWidth-1:0]   axi_wdata,
  output logic [AxiDataWidth/8-1:0] axi_wstrb,
  output logic                      axi_wvalid,
  input  logic                      axi_wready,
  input  logic                      axi_bvalid,
  output logic                      axi_bready,
  output logic [31:0]               axi_araddr,
  output logic [2:0]                axi_arsize,
  output logic                      axi_arvalid,
  input  logic                      axi_arready,
  input  logic [AxiDataWidth-1:0]   axi_rdata,
  input  logic                      axi_rvalid,
  output logic                      axi_rready
);

  core_pkg::mem_req_t issue_req;
  core_pkg::mem_req_t req;
  core_pkg::wb_t      res;
  core_pkg::wb_t      wb;
  logic               req_valid;
  logic               req_ready;
  logic               res_valid;
  logic               res_ready;

  axi_mem_if #(.AxiDataWidth(AxiDataWidth)) i_axi ();

  assign issue_req = '{lsu:        issue_lsu,
                       lsu_op:     issue_lsu_op,
                       alu_res:    issue_alu_res,
                       store_data: issue_store_data,
                       rd_en:      issue_rd_en,
                       rd_addr:    issue_rd_addr};

  pipe_buffer #(.payload_t(core_pkg::mem_req_t)) i_req_buffer (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (issue_valid),
    .in_ready (issue_ready),
    .in_data  (issue_req),
    .out_valid(req_valid),
    .out_ready(req_ready),
    .out_data (req)
  );

  mem_stage #(.AxiDataWidth(AxiDataWidth)) i_mem_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .req      (req),
    .res_valid(res_valid),
    .res_ready(res_ready),
    .res      (res),
    .axi      (i_axi.master)
  );

  pipe_buffer #(.payload_t(core_pkg::wb_t)) i_wb_buffer (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (res_valid),
    .in_ready (res_ready),
    .in_data  (res),
    .out_valid(wb_valid),
    .out_ready(wb_ready),
    .out_data (wb)
  );

  assign wb_rd_en   = wb.rd_en;
  assign wb_rd_addr = wb.rd_addr;
  assign wb_rd_data = wb.rd_data;

  // slave side of the bus out to the pins
  assign axi_awaddr    = i_axi.awaddr;
  assign axi_awsize    = i_axi.awsize;
  assign axi_awvalid   = i_axi.awvalid;
  assign i_axi.awready = axi_awready;
  assign axi_wdata     = i_axi.wdata;
  assign axi_wstrb     = i_axi.wstrb;
  assign axi_wvalid    = i_axi.wvalid;
  assign i_axi.wready  = axi_wready;
  assign i_axi.bvalid  = axi_bvalid;
  assign axi_bready    = i_axi.bready;
  assign axi_araddr    = i_axi.araddr;
  assign axi_arsize    = i_axi.arsize;
  assign axi_arvalid   = i_axi.arvalid;
  assign i_axi.arready = axi_arready;
  assign i_axi.rdata   = axi_rdata;
  assign i_axi.rvalid  = axi_rvalid;
  assign axi_rready    = i_axi.rready;

endmodule : mem_subsys

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int Period = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(Period / 2) clk = ~clk;
  end

endmodule : tb_clock

`default_nettype wire

//--- mem_subsys_checker.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_checker #(
  parameter int AxiDataWidth = 64
) (
  input logic                      clk,
  input logic                      rst_n,
  input logic [31:0]               axi_awaddr,
  input logic [2:0]                axi_awsize,
  input logic                      axi_awvalid,
  input logic                      axi_awready,
  input logic [AxiDataWidth-1:0]   axi_wdata,
  input logic [AxiDataWidth/8-1:0] axi_wstrb,
  input logic                      axi_wvalid,
  input logic                      axi_wready,
  input logic [31:0]               axi_araddr,
  input logic                      axi_arvalid,
  input logic                      axi_arready,
  input logic                      wb_valid,
  input logic                      wb_ready,
  input logic                      wb_rd_en,
  input core_pkg::reg_addr_t       wb_rd_addr,
  input core_pkg::reg_data_t       wb_rd_data
);

  // read by the testbench at the end of the run
  int fail_count = 0;

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axi_awvalid && !axi_awready |=>
      axi_awvalid && $stable(axi_awaddr) && $stable(axi_awsize))
    else begin
      fail_count++;
      $error("AW channel dropped or changed before awready");
    end

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axi_wvalid && !axi_wready |=> axi_wvalid && $stable(axi_wdata) && $stable(axi_wstrb))
    else begin
      fail_count++;
      $error("W channel dropped or changed before wready");
    end

  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr))
    else begin
      fail_count++;
      $error("AR channel dropped or changed before arready");
    end

  // only one transaction in flight at a time
  no_aw_ar: assert property (@(posedge clk) disable iff (!rst_n)
    !(axi_awvalid && axi_arvalid))
    else begin
      fail_count++;
      $error("awvalid and arvalid high together");
    end

  strb_size: assert property (@(posedge clk) disable iff (!rst_n)
    axi_wvalid |-> axi_wstrb != '0 && $countones(axi_wstrb) == (1 << axi_awsize))
    else begin
      fail_count++;
      $error("wstrb does not match the access size");
    end

  wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid && !wb_ready |=> wb_valid && $stable(wb_rd_en) && $stable(wb_rd_addr) &&
      $stable(wb_rd_data))
    else begin
      fail_count++;
      $error("writeback result dropped or changed before wb_ready");
    end

endmodule : mem_subsys_checker

`default_nettype wire

//--- mem_subsys_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_tb;

  localparam int ClkPeriod    = 100;
  localparam int AxiDataWidth = 64;
  localparam int MemBytes     = 256;
  localparam int RandOps      = 60;
  // alu, word pair, sub-word, random and store-only tests
  localparam int NumOps       = 1 + 2 + 36 + RandOps + 4;
  localparam int Seed         = 32'hee5a;

  logic                      clk;
  logic                      rst_n;
  logic                      issue_valid;
  logic                      issue_ready;
  logic                      issue_lsu;
  core_pkg::lsu_op_t         issue_lsu_op;
  core_pkg::reg_data_t       issue_alu_res;
  core_pkg::reg_data_t       issue_store_data;
  logic                      issue_rd_en;
  core_pkg::reg_addr_t       issue_rd_addr;
  logic                      wb_valid;
  logic                      wb_ready;
  logic                      wb_rd_en;
  core_pkg::reg_addr_t       wb_rd_addr;
  core_pkg::reg_data_t       wb_rd_data;
  logic [31:0]               axi_awaddr;
  logic [2:0]                axi_awsize;
  logic                      axi_awvalid;
  logic                      axi_awready;
  logic [AxiDataWidth-1:0]   axi_wdata;
  logic [AxiDataWidth/8-1:0] axi_wstrb;
  logic                      axi_wvalid;
  logic                      axi_wready;
  logic                      axi_bvalid;
  logic                      axi_bready;
  logic [31:0]               axi_araddr;
  logic [2:0]                axi_arsize;
  logic                      axi_arvalid;
  logic                      axi_arready;
  logic [AxiDataWidth-1:0]   axi_rdata;
  logic                      axi_rvalid;
  logic                      axi_rready;

  // stimulus and bus delays draw from separate streams
  int stim_seed  = Seed;
  int delay_seed = Seed;

  logic [AxiDataWidth-1:0]   axi_mem [MemBytes/8];
  logic [7:0]                ref_mem [MemBytes];
  core_pkg::wb_t             exp_q [$];
  int                        errors, checks, issued, retired;
  int                        cycle, accept_cycle, wb_cycle, axi_busy;
  core_pkg::reg_data_t       last_wb_data;
  logic                      rand_mode;
  logic                      aw_got, w_got, ar_got, b_clear, r_clear, b_armed, r_armed;
  int                        b_wait, r_wait;
  logic [31:0]               aw_addr_q, ar_addr_q;
  logic [2:0]                aw_size_q, ar_size_q;
  logic [AxiDataWidth-1:0]   w_data_q;
  logic [AxiDataWidth/8-1:0] w_strb_q;

  tb_clock #(.Period(ClkPeriod)) i_clock (.clk(clk));

  mem_subsys #(.AxiDataWidth(AxiDataWidth)) i_mem_subsys (.*);

  bind mem_subsys mem_subsys_checker #(.AxiDataWidth(AxiDataWidth)) i_checker (.*);

  task automatic expect_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s", $time, msg);
    end
  endtask

  // odd multiplier keeps every byte address distinct
  function automatic logic [7:0] fill_byte(input int addr);
    return 8'(addr * 29 + 8'h3c);
  endfunction

  function automatic core_pkg::reg_data_t ref_load(input core_pkg::lsu_op_t op,
                                                   input logic [31:0] addr);
    core_pkg::reg_data_t value;
    int nbytes;
    int i;
    nbytes = 1 << op[1:0];
    value  = '0;
    for (i = 0; i < nbytes; i++) begin
      value[8*i +: 8] = ref_mem[(addr + i) % MemBytes];
    end
    // signed loads copy the top loaded bit upward
    if (!op[2] && nbytes < 4 && value[8*nbytes-1]) begin
      value = value | (32'hffff_ffff << (8 * nbytes));
    end
    return value;
  endfunction

  function automatic void ref_store(input core_pkg::lsu_op_t op, input logic [31:0] addr,
                                    input core_pkg::reg_data_t data);
    int nbytes;
    int i;
    nbytes = 1 << op[1:0];
    for (i = 0; i < nbytes; i++) begin
      ref_mem[(addr + i) % MemBytes] = data[8*i +: 8];
    end
  endfunction

  function automatic logic rand_ready();
    return rand_mode ? logic'($random(delay_seed) & 1) : 1'b1;
  endfunction

  function automatic int rand_delay();
    return rand_mode ? ($random(delay_seed) & 3) : 0;
  endfunction

  task automatic axi_write(input logic [31:0] addr, input logic [AxiDataWidth-1:0] data,
                           input logic [AxiDataWidth/8-1:0] strb);
    int lane;
    for (lane = 0; lane < AxiDataWidth / 8; lane++) begin
      if (strb[lane]) begin
        axi_mem[addr[7:3]][8*lane +: 8] = data[8*lane +: 8];
      end
    end
  endtask

  // handshakes are taken at the rising edge
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (axi_awvalid || axi_wvalid || axi_arvalid) begin
      axi_busy++;
    end
    if (axi_awvalid && axi_awready) begin
      aw_got    = 1'b1;
      aw_addr_q = axi_awaddr;
      aw_size_q = axi_awsize;
    end
    if (axi_wvalid && axi_wready) begin
      w_got    = 1'b1;
      w_data_q = axi_wdata;
      w_strb_q = axi_wstrb;
    end
    if (axi_arvalid && axi_arready) begin
      ar_got    = 1'b1;
      ar_addr_q = axi_araddr;
      ar_size_q = axi_arsize;
    end
    if (axi_bvalid && axi_bready) begin
      b_clear = 1'b1;
    end
    if (axi_rvalid && axi_rready) begin
      r_clear = 1'b1;
    end
  end

  // slave responses and all readies change on the falling edge
  always @(negedge clk) begin
    if (b_clear) begin
      axi_bvalid = 1'b0;
      b_clear    = 1'b0;
    end
    if (r_clear) begin
      axi_rvalid = 1'b0;
      r_clear    = 1'b0;
    end
    if (aw_got && w_got) begin
      axi_write(aw_addr_q, w_data_q, w_strb_q);
      aw_got  = 1'b0;
      w_got   = 1'b0;
      b_wait  = rand_delay();
      b_armed = 1'b1;
    end
    if (b_armed) begin
      if (b_wait == 0) begin
        axi_bvalid = 1'b1;
        b_armed    = 1'b0;
      end else begin
        b_wait--;
      end
    end
    if (ar_got) begin
      axi_rdata = axi_mem[ar_addr_q[7:3]];
      ar_got    = 1'b0;
      r_wait    = rand_delay();
      r_armed   = 1'b1;
    end
    if (r_armed) begin
      if (r_wait == 0) begin
        axi_rvalid = 1'b1;
        r_armed    = 1'b0;
      end else begin
        r_wait--;
      end
    end
    axi_awready = rand_ready();
    axi_wready  = rand_ready();
    axi_arready = rand_ready();
    wb_ready    = rand_ready();
  end

  always @(posedge clk) begin : wb_monitor
    core_pkg::wb_t exp;
    if (rst_n && wb_valid && wb_ready) begin
      retired++;
      wb_cycle     = cycle;
      last_wb_data = wb_rd_data;
      if (exp_q.size() == 0) begin
        errors++;
        $display("writeback at %0t arrived with no instruction pending", $time);
      end else begin
        exp = exp_q.pop_front();
        expect_true(wb_rd_en == exp.rd_en && wb_rd_addr == exp.rd_addr &&
                    wb_rd_data == exp.rd_data,
                    $sformatf("writeback en=%0b rd=%0d data=%h, expected en=%0b rd=%0d data=%h",
                              wb_rd_en, wb_rd_addr, wb_rd_data,
                              exp.rd_en, exp.rd_addr, exp.rd_data));
      end
    end
  end

  // entered and left on a falling edge
  task automatic issue(input logic lsu, input core_pkg::lsu_op_t op,
                       input core_pkg::reg_data_t alu, input core_pkg::reg_data_t sdata,
                       input logic rd_en, input core_pkg::reg_addr_t rd);
    core_pkg::wb_t exp;
    exp.rd_en   = rd_en;
    exp.rd_addr = rd;
    exp.rd_data = alu;
    if (lsu && op[core_pkg::LsuLoadBit]) begin
      exp.rd_data = ref_load(op, alu);
    end else if (lsu) begin
      ref_store(op, alu, sdata);
    end
    exp_q.push_back(exp);
    issued++;
    issue_lsu        = lsu;
    issue_lsu_op     = op;
    issue_alu_res    = alu;
    issue_store_data = sdata;
    issue_rd_en      = rd_en;
    issue_rd_addr    = rd;
    issue_valid      = 1'b1;
    @(posedge clk);
    while (!issue_ready) begin
      @(posedge clk);
    end
    accept_cycle = cycle;
    @(negedge clk);
    issue_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic store_and_check(input logic [1:0] size, input logic [31:0] addr,
                                 input core_pkg::reg_data_t data);
    logic [AxiDataWidth/8-1:0] strb;
    int nbytes;
    int i;
    issue(1'b1, {2'b00, size}, addr, data, 1'b0, 5'd0);
    wait_idle();
    nbytes = 1 << size;
    strb   = (AxiDataWidth/8)'((1 << nbytes) - 1) << addr[2:0];
    expect_true(aw_size_q == {1'b0, size},
                $sformatf("awsize %0d for a %0d-byte store", aw_size_q, nbytes));
    expect_true(w_strb_q == strb, $sformatf("wstrb %h for address %h, expected %h",
                                            w_strb_q, addr, strb));
    for (i = 0; i < nbytes; i++) begin
      expect_true(w_data_q[8*(addr[2:0]+i) +: 8] == data[8*i +: 8],
                  $sformatf("write lane %0d wrong for address %h", addr[2:0] + i, addr));
    end
  endtask

  task automatic test_alu_pass();
    int busy_before;
    expect_true(!wb_valid && !axi_awvalid && !axi_wvalid && !axi_arvalid &&
                !axi_bready && !axi_rready, "outputs not idle after reset");
    expect_true(issue_ready, "issue_ready low after reset");
    busy_before = axi_busy;
    issue(1'b0, 4'h0, 32'h1234_5678, 32'h0, 1'b1, 5'd7);
    wait_idle();
    expect_true(wb_cycle - accept_cycle == 2,
                $sformatf("ALU result took %0d cycles", wb_cycle - accept_cycle));
    expect_true(axi_busy == busy_before, "AXI activity for a non-memory instruction");
  endtask

  task automatic test_word_pair();
    store_and_check(2'd2, 32'h44, 32'hdead_beef);
    issue(1'b1, 4'b1010, 32'h44, 32'h0, 1'b1, 5'd3);
    wait_idle();
    expect_true(ar_size_q == 3'd2, $sformatf("arsize %0d for a word load", ar_size_q));
    expect_true(last_wb_data == 32'hdead_beef,
                $sformatf("word load returned %h", last_wb_data));
  endtask

  task automatic test_sub_word();
    int i;
    // mixed sign bits in the stored bytes and halves
    for (i = 0; i < 8; i++) begin
      store_and_check(2'd0, 32'h80 + i, 32'hc3a5_5a00 + i * 32'h27 + 32'h6b);
    end
    for (i = 0; i < 4; i++) begin
      store_and_check(2'd1, 32'h90 + 2 * i, 32'h1234_0000 + i * 32'h3c71 + 32'h7f80);
    end
    for (i = 0; i < 8; i++) begin
      issue(1'b1, 4'b1000, 32'h80 + i, 32'h0, 1'b1, 5'(i));
      issue(1'b1, 4'b1100, 32'h80 + i, 32'h0, 1'b1, 5'(i + 8));
    end
    for (i = 0; i < 4; i++) begin
      issue(1'b1, 4'b1001, 32'h90 + 2 * i, 32'h0, 1'b1, 5'(i + 16));
      issue(1'b1, 4'b1101, 32'h90 + 2 * i, 32'h0, 1'b1, 5'(i + 20));
    end
    wait_idle();
  endtask

  task automatic test_random_mix();
    int n;
    int kind;
    logic [1:0] size;
    logic [31:0] addr;
    logic [31:0] data;
    core_pkg::reg_addr_t rd;
    rand_mode = 1'b1;
    for (n = 0; n < RandOps; n++) begin
      kind = ($random(stim_seed) & 32'h7fff_ffff) % 3;
      size = 2'(($random(stim_seed) & 32'h7fff_ffff) % 3);
      addr = ($random(stim_seed) & (MemBytes - 1)) & ~((1 << size) - 1);
      data = $random(stim_seed);
      rd   = 5'($random(stim_seed));
      if (kind == 0) begin
        issue(1'b0, 4'h0, data, 32'h0, 1'b1, rd);
      end else if (kind == 1) begin
        issue(1'b1, {2'b00, size}, addr, data, 1'b0, rd);
      end else begin
        issue(1'b1, {1'b1, data[31], size}, addr, 32'h0, 1'b1, rd);
      end
    end
    wait_idle();
    rand_mode = 1'b0;
  endtask

  task automatic test_store_memory();
    int a;
    int mismatches;
    issue(1'b1, 4'b0010, 32'hf0, 32'h0bad_cafe, 1'b0, 5'd9);
    issue(1'b1, 4'b0000, 32'hf5, 32'h0000_0081, 1'b0, 5'd10);
    issue(1'b1, 4'b0001, 32'hfa, 32'h0000_9e37, 1'b0, 5'd11);
    issue(1'b1, 4'b0010, 32'h04, 32'h7654_3210, 1'b0, 5'd12);
    wait_idle();
    mismatches = 0;
    for (a = 0; a < MemBytes; a++) begin
      if (axi_mem[a / 8][8*(a % 8) +: 8] != ref_mem[a]) begin
        mismatches++;
      end
    end
    expect_true(mismatches == 0, $sformatf("%0d memory bytes differ from the model", mismatches));
  endtask

  initial begin
    #((NumOps * 40 + 10) * ClkPeriod);
    $display("watchdog expired with %0d results still pending", exp_q.size());
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int a;
    rst_n            = 1'b0;
    issue_valid      = 1'b0;
    issue_lsu        = 1'b0;
    issue_lsu_op     = '0;
    issue_alu_res    = '0;
    issue_store_data = '0;
    issue_rd_en      = 1'b0;
    issue_rd_addr    = '0;
    wb_ready         = 1'b1;
    axi_awready      = 1'b1;
    axi_wready       = 1'b1;
    axi_bvalid       = 1'b0;
    axi_arready      = 1'b1;
    axi_rdata        = '0;
    axi_rvalid       = 1'b0;
    {errors, checks, issued, retired} = '0;
    {cycle, accept_cycle, wb_cycle, axi_busy} = '0;
    {aw_got, w_got, ar_got, b_clear, r_clear, b_armed, r_armed} = '0;
    rand_mode = 1'b0;
    for (a = 0; a < MemBytes; a++) begin
      axi_mem[a / 8][8*(a % 8) +: 8] = fill_byte(a);
      ref_mem[a] = fill_byte(a);
    end
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    test_alu_pass();
    test_word_pair();
    test_sub_word();
    test_random_mix();
    test_store_memory();
    expect_true(issued == retired, $sformatf("issued %0d, retired %0d", issued, retired));
    errors += i_mem_subsys.i_checker.fail_count;
    $display("checks: %0d, errors: %0d, issued: %0d, retired: %0d",
             checks, errors, issued, retired);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : mem_subsys_tb

`default_nettype wire

//--- src.f
core_pkg.sv
axi_mem_if.sv
pipe_buffer.sv
lsu_align.sv
mem_stage.sv
mem_subsys.sv
tb_clock.sv
mem_subsys_checker.sv
mem_subsys_tb.sv
